/* list.f */
+incdir+rtl
rtl/alu_pkg.sv
rtl/alu_input_stage.sv
rtl/alu_operand_latch.sv
rtl/alu_nibble_engine.sv
rtl/alu.sv
tests/alu_tb.sv

/* run.sh */
#!/bin/sh
# Builds the ALU testbench with Verilator, runs it and checks the log for the pass line

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
    -f list.f --top-module alu_tb -Mdir obj_dir > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/Valu_tb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" "$SIM_LOG"; then
    exit 0
fi
echo "Pass line not found in $SIM_LOG"
exit 1

/* tests/alu_tb.sv */
// Testbench plays the flag-keeping caller; it stops at the first mismatch and needs --assert
`timescale 1ns/1ns
`include "alu_defines.svh"

module alu_tb;
    import alu_pkg::*;

    typedef struct packed
    {
        data_t res;                                     // Result byte after step B
        logic  hc;                                      // Carry out of step A
        logic  cy;                                      // Carry out of step B
        logic  par;                                     // Chained parity
        logic  zero;                                    // Result byte is zero
    } model_t;

    // ------------------------------------------------------------
    // DUT signals
    // ------------------------------------------------------------
    logic  clk, reset, alu_oe, db_oe;
    data_t db_in, db_out;
    logic  alu_op1_oe, alu_op2_oe, alu_res_oe, alu_shift_oe, alu_bs_oe;    // Bus writers
    logic  alu_shift_in, alu_shift_left, alu_shift_right, shift_db0, shift_db7;
    bsel_t bsel;
    logic  alu_op1_sel_bus, alu_op1_sel_low, alu_op1_sel_zero;             // OP1 loads
    logic  alu_op2_sel_bus, alu_op2_sel_lq, alu_op2_sel_zero;              // OP2 loads
    logic  alu_sel_op2_high, alu_sel_op2_neg;
    logic  alu_core_cf_in, core_r, core_s, core_v, alu_op_low, alu_parity_in;
    logic  alu_core_cf_out, alu_parity_out, alu_zero;
    logic  alu_low_gt_9, alu_high_gt_9, alu_high_eq_9;

    logic       chk_bus, chk_cy, chk_flags, chk_shift, chk_bcd;           // Checker enables
    data_t      exp_bus;
    logic       exp_cy, exp_par, exp_zero;
    logic [1:0] exp_shift;                              // {bit 7, bit 0}
    logic [2:0] exp_bcd;                                // {low gt 9, high gt 9, high eq 9}
    logic       hc;                                     // Caller's half-carry flag
    logic       plow;                                   // Caller's low-step parity

    alu dut0 (.*);

    initial
    begin
        clk = 1'b0;
        forever
            #20 clk = ~clk;                             // 40 ns period
    end

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------
    // op is {core_r, core_s, core_v}; step B takes the carry of step A
    function automatic model_t alu_model(input data_t a, input data_t b, input logic [2:0] op,
                                         input logic neg, input logic cin, input logic pin);
        model_t     r;
        nibble_t    x;
        nibble_t    y;
        nibble_t    n;
        logic [4:0] s;
        logic       c;
        int         i;
        c    = cin;
        r    = '0;
        for (i = 0; i < 2; i++)
        begin
            x = a[`ALU_NIB_W*i +: `ALU_NIB_W];
            y = neg ? ~b[`ALU_NIB_W*i +: `ALU_NIB_W] : b[`ALU_NIB_W*i +: `ALU_NIB_W];
            s = {1'b0, x} + {1'b0, y} + {4'b0, c};
            c = 1'b0;                                   // Logic ops and pass clear it
            if (op[0])
                n = y;
            else
            begin
                case (op[2:1])
                    2'b00:   {c, n} = s;
                    2'b10:   n = x & y;
                    2'b01:   n = x | y;
                    default: n = x ^ y;
                endcase
            end
            r.res[`ALU_NIB_W*i +: `ALU_NIB_W] = n;
            if (i == 0)
                r.hc = c;
        end
        r.cy   = c;
        r.par  = (^r.res) ^ pin;
        r.zero = (r.res == 8'h00);
        return r;
    endfunction

    function automatic data_t bcd_byte();
        logic [31:0] r;
        r = $urandom;
        return {nibble_t'(r[15:0] % 10), nibble_t'(r[31:16] % 10)};   // Two decimal digits
    endfunction

    // ------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------
    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic clear_controls();
        {alu_op1_oe, alu_op2_oe, alu_res_oe, alu_shift_oe, alu_bs_oe} = '0;
        {alu_shift_in, alu_shift_left, alu_shift_right} = '0;
        {alu_op1_sel_bus, alu_op1_sel_low, alu_op1_sel_zero} = '0;
        {alu_op2_sel_bus, alu_op2_sel_lq, alu_op2_sel_zero} = '0;
        {alu_sel_op2_high, alu_sel_op2_neg, alu_op_low} = '0;
        {alu_core_cf_in, core_r, core_s, core_v, alu_parity_in} = '0;
        {chk_bus, chk_cy, chk_flags, chk_shift, chk_bcd} = '0;
        bsel = '0;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;                                             // Drive just after the edge
        clear_controls();
    endtask

    task automatic load_operands(input data_t a, input data_t b);
        next_cycle();
        db_in           = a;
        alu_shift_oe    = 1'b1;                         // Unshifted byte onto the bus
        alu_op1_sel_bus = 1'b1;
        next_cycle();
        db_in           = b;
        alu_shift_oe    = 1'b1;
        alu_op2_sel_bus = 1'b1;
    endtask

    task automatic read_op(input logic second, input data_t want);
        next_cycle();
        alu_op1_oe = !second;
        alu_op2_oe = second;
        chk_bus    = 1'b1;
        exp_bus    = want;
    endtask

    // Adjust loads OP1 with the result and OP2 with the decimal correction at the end of step B
    task automatic two_step(input data_t a, input data_t b, input logic [2:0] op,
                            input logic neg, input logic cin, input logic pin,
                            input logic adjust, output model_t mr);
        mr = alu_model(a, b, op, neg, cin, pin);
        next_cycle();                                   // Step A, low nibbles
        {core_r, core_s, core_v} = op;
        alu_sel_op2_neg = neg;
        alu_core_cf_in  = cin;
        alu_parity_in   = pin;
        alu_op_low      = 1'b1;
        chk_cy          = 1'b1;
        exp_cy          = mr.hc;
        @(negedge clk);
        hc   = alu_core_cf_out;
        plow = alu_parity_out;
        next_cycle();                                   // Step B, high nibbles
        {core_r, core_s, core_v} = op;
        alu_sel_op2_neg  = neg;
        alu_sel_op2_high = 1'b1;
        alu_core_cf_in   = hc;
        alu_parity_in    = plow;
        alu_res_oe       = 1'b1;
        alu_op1_sel_bus  = adjust;
        alu_op2_sel_lq   = adjust;
        {chk_bus, chk_cy, chk_flags, chk_bcd} = '1;
        exp_bus  = mr.res;
        exp_cy   = mr.cy;
        exp_par  = mr.par;
        exp_zero = mr.zero;
        exp_bcd  = {mr.res[3:0] > 4'd9, mr.res[7:4] > 4'd9, mr.res[7:4] == 4'd9};
    endtask

    task automatic wait_idle(input int limit);
        int n;
        n = 0;
        while ((db_oe !== 1'b0 || db_out !== 8'h00) && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if (db_oe !== 1'b0 || db_out !== 8'h00)
            report_error("Bus did not go idle after reset within the timeout");
    endtask

    // ------------------------------------------------------------
    // Checker sampling at the falling edge
    // ------------------------------------------------------------
    always @(negedge clk)
    begin
        assert (db_oe == alu_oe)
        else report_error($sformatf("Fail at %0t ns: db_oe %b, alu_oe %b", $time, db_oe, alu_oe));
        if (chk_bus)
            assert (db_out == exp_bus)
            else report_error($sformatf("Fail at %0t ns: db_out %h, expected %h",
                                        $time, db_out, exp_bus));
        if (chk_cy)
            assert (alu_core_cf_out == exp_cy)
            else report_error($sformatf("Fail at %0t ns: carry %b, expected %b",
                                        $time, alu_core_cf_out, exp_cy));
        if (chk_flags)
            assert ({alu_parity_out, alu_zero} == {exp_par, exp_zero})
            else report_error($sformatf("Fail at %0t ns: parity/zero %b%b, expected %b%b",
                                        $time, alu_parity_out, alu_zero, exp_par, exp_zero));
        if (chk_shift)
            assert ({shift_db7, shift_db0} == exp_shift)
            else report_error($sformatf("Fail at %0t ns: shift edge bits %b%b, expected %b",
                                        $time, shift_db7, shift_db0, exp_shift));
        if (chk_bcd)
            assert ({alu_low_gt_9, alu_high_gt_9, alu_high_eq_9} == exp_bcd)
            else report_error($sformatf("Fail at %0t ns: BCD flags %b%b%b, expected %b", $time,
                                        alu_low_gt_9, alu_high_gt_9, alu_high_eq_9, exp_bcd));
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial
    begin
        model_t      m1;
        model_t      m2;
        data_t       a;
        data_t       b;
        data_t       want;
        logic [31:0] rnd;
        int          mode;
        int          i;
        void'($urandom(32'h6a914581));
        reset  = 1'b1;
        alu_oe = 1'b0;
        db_in  = '0;
        clear_controls();
        repeat (16)
            @(posedge clk);
        #2 reset = 1'b0;

        wait_idle(8);                                   // Direction and idle bus
        next_cycle();
        chk_bus = 1'b1;
        exp_bus = '0;
        alu_oe  = 1'b1;

        for (i = 0; i < 40; i++)                        // Shifter into OP1
        begin
            rnd  = $urandom;
            a    = data_t'($urandom);
            mode = rnd % 3;
            case (mode)
                1:       want = {a[6:0], rnd[8]};
                2:       want = {rnd[8], a[7:1]};
                default: want = a;
            endcase
            next_cycle();
            db_in           = a;
            alu_shift_in    = rnd[8];
            alu_shift_left  = (mode == 1);
            alu_shift_right = (mode == 2);
            alu_shift_oe    = 1'b1;
            alu_op1_sel_bus = 1'b1;
            chk_shift       = 1'b1;
            exp_shift       = {want[7], want[0]};
            read_op(1'b0, want);
        end

        for (i = 0; i < 8; i++)                         // Bit selector into OP2
        begin
            next_cycle();
            bsel            = bsel_t'(i);
            alu_bs_oe       = 1'b1;
            alu_op2_sel_bus = 1'b1;
            read_op(1'b1, data_t'(1) << i);
        end
        next_cycle();
        alu_op1_sel_zero = 1'b1;
        alu_op2_sel_zero = 1'b1;
        read_op(1'b0, '0);
        read_op(1'b1, '0);

        load_operands(8'h8c, 8'h6d);                    // Known sum with half-carry
        two_step(8'h8c, 8'h6d, 3'b000, 1'b0, 1'b0, 1'b0, 1'b0, m1);
        assert (m1.res == 8'hf9 && m1.hc && !m1.cy)
        else report_error("Reference model gives the wrong sum for 8C + 6D");
        load_operands(8'hff, 8'h01);                    // Wraps to zero with carry
        two_step(8'hff, 8'h01, 3'b000, 1'b0, 1'b0, 1'b0, 1'b0, m1);
        for (i = 0; i < 200; i++)
        begin
            rnd = $urandom;
            a   = data_t'($urandom);
            b   = data_t'($urandom);
            load_operands(a, b);
            two_step(a, b, 3'b000, 1'b0, rnd[0], rnd[1], 1'b0, m1);
        end

        for (i = 0; i < 150; i++)                       // All op codes with OP2 maybe inverted
        begin
            rnd = $urandom;
            a   = data_t'($urandom);
            b   = data_t'($urandom);
            load_operands(a, b);
            two_step(a, b, rnd[2:0], rnd[3], rnd[4], rnd[5], 1'b0, m1);
        end

        for (i = 0; i < 50; i++)                        // BCD add and decimal adjust
        begin
            a = bcd_byte();
            b = bcd_byte();
            load_operands(a, b);
            two_step(a, b, 3'b000, 1'b0, 1'b0, 1'b0, 1'b1, m1);
            want = {(m1.res[7:4] > 4'd9) ? 4'd6 : 4'd0, (m1.res[3:0] > 4'd9) ? 4'd6 : 4'd0};
            read_op(1'b0, m1.res);
            read_op(1'b1, want);
            two_step(m1.res, want, 3'b000, 1'b0, 1'b0, 1'b0, 1'b0, m2);
            next_cycle();
            alu_op1_sel_low = 1'b1;                     // Low nibble into both halves
            read_op(1'b0, {m2.res[3:0], m2.res[3:0]});
        end

        load_operands(8'h5a, 8'ha5);                    // Every bus source nonzero
        next_cycle();
        db_in   = 8'h3c;
        bsel    = 3'd5;
        chk_bus = 1'b1;
        exp_bus = '0;                                   // No writer strobe high

        next_cycle();
        $display("Test passed");
        $finish;
    end

endmodule

/* rtl/alu.sv */
// Bus is split into db_in/db_out/db_oe; flag registers and sequencing stay with the caller
`timescale 1ns/1ns

module alu
(
    input  logic             clk,
    input  logic             reset,             // Synchronous, active high
    // External bus
    input  logic             alu_oe,            // Caller is not driving the bus
    input  alu_pkg::data_t   db_in,             // Byte from the external bus
    output alu_pkg::data_t   db_out,            // Internal bus towards the outside
    output logic             db_oe,             // Enable for db_out
    // Internal bus writers
    input  logic             alu_op1_oe,
    input  logic             alu_op2_oe,
    input  logic             alu_res_oe,
    input  logic             alu_shift_oe,
    input  logic             alu_bs_oe,
    // Input stage
    input  logic             alu_shift_in,
    input  logic             alu_shift_left,
    input  logic             alu_shift_right,
    input  alu_pkg::bsel_t   bsel,
    output logic             shift_db0,         // Shifter bit 0 for rotate flags
    output logic             shift_db7,         // Shifter bit 7 for rotate flags
    // Operand latch selects
    input  logic             alu_op1_sel_bus,
    input  logic             alu_op1_sel_low,
    input  logic             alu_op1_sel_zero,
    input  logic             alu_op2_sel_bus,
    input  logic             alu_op2_sel_lq,
    input  logic             alu_op2_sel_zero,
    input  logic             alu_sel_op2_high,
    input  logic             alu_sel_op2_neg,
    // Core
    input  logic             alu_core_cf_in,
    input  logic             core_r,
    input  logic             core_s,
    input  logic             core_v,
    input  logic             alu_op_low,
    input  logic             alu_parity_in,
    output logic             alu_core_cf_out,
    // Detectors
    output logic             alu_parity_out,
    output logic             alu_zero,
    output logic             alu_low_gt_9,
    output logic             alu_high_gt_9,
    output logic             alu_high_eq_9
);
    import alu_pkg::*;

    data_t   shift_byte;                        // Shifter to bus mux
    data_t   bs_byte;                           // Bit selector to bus mux
    data_t   bus;                               // Internal data bus
    data_t   op1;                               // OP1 latch byte
    data_t   op2;                               // OP2 latch byte
    nibble_t op1_nib;                           // Core operand A
    nibble_t op2_nib;                           // Core operand B
    nibble_t res_low;                           // Stored low result nibble

    // ------------------------------------------------------------
    // External bus
    // ------------------------------------------------------------
    assign db_out = bus;                        // Always the internal bus
    assign db_oe  = alu_oe;

    // ------------------------------------------------------------
    // Blocks
    // ------------------------------------------------------------
    alu_input_stage input_stage0
    (
        .db_in, .alu_shift_in, .alu_shift_left, .alu_shift_right, .bsel,
        .shift_byte, .bs_byte, .shift_db0, .shift_db7
    );

    alu_operand_latch operand_latch0
    (
        .clk, .reset, .bus, .res_low,
        .low_gt_9         (alu_low_gt_9),       // Flags feed the adjust gates
        .high_gt_9        (alu_high_gt_9),
        .alu_op1_sel_bus, .alu_op1_sel_low, .alu_op1_sel_zero,
        .alu_op2_sel_bus, .alu_op2_sel_lq, .alu_op2_sel_zero,
        .alu_sel_op2_high, .alu_sel_op2_neg,
        .op1, .op2, .op1_nib, .op2_nib
    );

    alu_nibble_engine nibble_engine0
    (
        .clk, .reset,
        .alu_op1_oe, .alu_op2_oe, .alu_res_oe, .alu_shift_oe, .alu_bs_oe,
        .shift_byte, .bs_byte, .op1, .op2, .op1_nib, .op2_nib,
        .alu_core_cf_in, .core_r, .core_s, .core_v, .alu_op_low, .alu_parity_in,
        .bus, .res_low, .alu_core_cf_out, .alu_parity_out, .alu_zero,
        .alu_low_gt_9, .alu_high_gt_9, .alu_high_eq_9
    );

endmodule

/* rtl/alu_nibble_engine.sv */
// Core is combinational; only the low result nibble is stored, the high half stays live
`timescale 1ns/1ns
`include "alu_defines.svh"

module alu_nibble_engine
(
    input  logic             clk,
    input  logic             reset,             // Synchronous, clears the result latch
    input  logic             alu_op1_oe,        // OP1 writes the internal bus
    input  logic             alu_op2_oe,        // OP2 writes the internal bus
    input  logic             alu_res_oe,        // Result writes the internal bus
    input  logic             alu_shift_oe,      // Shifter writes the internal bus
    input  logic             alu_bs_oe,         // Bit selector writes the internal bus
    input  alu_pkg::data_t   shift_byte,        // From the input shifter
    input  alu_pkg::data_t   bs_byte,           // From the bit selector
    input  alu_pkg::data_t   op1,               // OP1 latch byte
    input  alu_pkg::data_t   op2,               // OP2 latch byte
    input  alu_pkg::nibble_t op1_nib,           // Selected OP1 nibble
    input  alu_pkg::nibble_t op2_nib,           // Selected OP2 nibble
    input  logic             alu_core_cf_in,    // Carry into the adder
    input  logic             core_r,            // Operation bit R
    input  logic             core_s,            // Operation bit S
    input  logic             core_v,            // Operation bit V, pass OP2
    input  logic             alu_op_low,        // Store the core nibble as low result
    input  logic             alu_parity_in,     // Parity chained from the previous step
    output alu_pkg::data_t   bus,               // Internal data bus
    output alu_pkg::nibble_t res_low,           // Stored low result nibble
    output logic             alu_core_cf_out,   // Nibble carry out
    output logic             alu_parity_out,    // Chained parity
    output logic             alu_zero,          // Result byte is zero
    output logic             alu_low_gt_9,      // Stored low nibble above 9
    output logic             alu_high_gt_9,     // Core nibble above 9
    output logic             alu_high_eq_9      // Core nibble equal to 9
);
    import alu_pkg::*;

    localparam nibble_t BCD_MAX = 4'd9;         // Largest valid BCD digit

    nibble_t             core_nib;              // Live core result
    logic [`ALU_NIB_W:0] sum;                   // Adder result with carry bit
    data_t               res_byte;              // Live high half over stored low half

    // ------------------------------------------------------------
    // Internal bus writer
    // ------------------------------------------------------------
    // Strobes are meant to be one-hot; the chain only settles overlaps
    always_comb
    begin
        if (alu_op1_oe)
            bus = op1;
        else if (alu_op2_oe)
            bus = op2;
        else if (alu_res_oe)
            bus = res_byte;
        else if (alu_shift_oe)
            bus = shift_byte;
        else if (alu_bs_oe)
            bus = bs_byte;
        else
            bus = '0;                           // Nobody driving
    end

    // ------------------------------------------------------------
    // 4-bit core
    // ------------------------------------------------------------
    assign sum = {1'b0, op1_nib} + {1'b0, op2_nib}
               + {{`ALU_NIB_W{1'b0}}, alu_core_cf_in};

    always_comb
    begin
        alu_core_cf_out = 1'b0;                 // Only ADD produces a carry
        if (core_v)
            core_nib = op2_nib;                 // Pass ignores R and S
        else
        begin
            case ({core_r, core_s})
                2'b00:
                begin
                    core_nib        = sum[`ALU_NIB_W-1:0];
                    alu_core_cf_out = sum[`ALU_NIB_W];
                end
                2'b10:   core_nib = op1_nib & op2_nib;  // AND
                2'b01:   core_nib = op1_nib | op2_nib;  // OR
                default: core_nib = op1_nib ^ op2_nib;  // XOR
            endcase
        end
    end

    // ------------------------------------------------------------
    // Result latch
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
            res_low <= '0;
        else if (alu_op_low)
            res_low <= core_nib;                // Captured at the end of step A
    end

    assign res_byte = {core_nib, res_low};      // High half follows the core in step B

    // ------------------------------------------------------------
    // Detectors
    // ------------------------------------------------------------
    // Parity bit that makes the ones count even, accumulated over both steps
    assign alu_parity_out = (^core_nib) ^ alu_parity_in;
    assign alu_zero       = (res_byte == '0);
    assign alu_low_gt_9   = (res_low > BCD_MAX);   // Low digit needs adjust
    assign alu_high_gt_9  = (core_nib > BCD_MAX);  // High digit needs adjust
    assign alu_high_eq_9  = (core_nib == BCD_MAX); // Caller uses this with the low carry

endmodule

/* rtl/alu_operand_latch.sv */
// Operand registers load on the edge after a select; bus beats special source beats zero
`timescale 1ns/1ns
`include "alu_defines.svh"

module alu_operand_latch
(
    input  logic             clk,
    input  logic             reset,             // Synchronous, clears both latches
    input  alu_pkg::data_t   bus,               // Internal data bus
    input  alu_pkg::nibble_t res_low,           // Stored low result nibble
    input  logic             low_gt_9,          // Low result nibble above 9
    input  logic             high_gt_9,         // High result nibble above 9
    input  logic             alu_op1_sel_bus,   // OP1 from the internal bus
    input  logic             alu_op1_sel_low,   // OP1 from the low result nibble
    input  logic             alu_op1_sel_zero,  // OP1 cleared
    input  logic             alu_op2_sel_bus,   // OP2 from the internal bus
    input  logic             alu_op2_sel_lq,    // OP2 from the decimal-adjust gates
    input  logic             alu_op2_sel_zero,  // OP2 cleared
    input  logic             alu_sel_op2_high,  // Use high nibbles instead of low
    input  logic             alu_sel_op2_neg,   // Complement the OP2 nibble
    output alu_pkg::data_t   op1,               // OP1 byte for the bus mux
    output alu_pkg::data_t   op2,               // OP2 byte for the bus mux
    output alu_pkg::nibble_t op1_nib,           // OP1 nibble into the core
    output alu_pkg::nibble_t op2_nib            // OP2 nibble into the core
);
    import alu_pkg::*;

    localparam nibble_t DAA_FIX = 4'd6;         // Decimal-adjust correction per nibble

    nibble_t lq_low;                            // Low correction nibble
    nibble_t lq_high;                           // High correction nibble
    data_t   lq_byte;                           // Full correction byte for OP2
    nibble_t op2_sel;                           // OP2 nibble before complement

    // ------------------------------------------------------------
    // Decimal-adjust correction
    // ------------------------------------------------------------
    assign lq_low  = low_gt_9  ? DAA_FIX : '0;  // Add 6 if the low digit overflowed
    assign lq_high = high_gt_9 ? DAA_FIX : '0;  // Add 6 if the high digit overflowed
    assign lq_byte = {lq_high, lq_low};

    // ------------------------------------------------------------
    // OP1 latch
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
            op1 <= '0;
        else if (alu_op1_sel_bus)
            op1 <= bus;
        else if (alu_op1_sel_low)
            op1 <= {res_low, res_low};          // Low nibble repeated in both halves
        else if (alu_op1_sel_zero)
            op1 <= '0;
    end

    // ------------------------------------------------------------
    // OP2 latch
    // ------------------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
            op2 <= '0;
        else if (alu_op2_sel_bus)
            op2 <= bus;
        else if (alu_op2_sel_lq)
            op2 <= lq_byte;                     // Correction built from gt-9 flags
        else if (alu_op2_sel_zero)
            op2 <= '0;
    end

    // ------------------------------------------------------------
    // Nibble selection into the core
    // ------------------------------------------------------------
    // One select steers both operands so the two halves stay aligned
    assign op1_nib = alu_sel_op2_high ? op1[`ALU_DATA_W-1:`ALU_NIB_W]
                                      : op1[`ALU_NIB_W-1:0];
    assign op2_sel = alu_sel_op2_high ? op2[`ALU_DATA_W-1:`ALU_NIB_W]
                                      : op2[`ALU_NIB_W-1:0];

    assign op2_nib = alu_sel_op2_neg ? ~op2_sel : op2_sel;  // Ones complement for subtract

endmodule

/* rtl/alu_input_stage.sv */
// Purely combinational; if both shift strobes are high the left shift wins
`timescale 1ns/1ns
`include "alu_defines.svh"

module alu_input_stage
(
    input  alu_pkg::data_t db_in,           // Byte from the external bus
    input  logic           alu_shift_in,    // Bit shifted into the vacated end
    input  logic           alu_shift_left,  // Shift towards bit 7
    input  logic           alu_shift_right, // Shift towards bit 0
    input  alu_pkg::bsel_t bsel,            // Bit to raise in the bit selector
    output alu_pkg::data_t shift_byte,      // Shifter result for the internal bus
    output alu_pkg::data_t bs_byte,         // One-hot byte for the internal bus
    output logic           shift_db0,       // Bit 0 of the shifter result
    output logic           shift_db7        // Bit 7 of the shifter result
);
    import alu_pkg::*;

    data_t shl_byte;                        // Candidate for a left shift
    data_t shr_byte;                        // Candidate for a right shift

    // ------------------------------------------------------------
    // Shifter
    // ------------------------------------------------------------
    assign shl_byte = {db_in[`ALU_DATA_W-2:0], alu_shift_in}; // Carry-in lands in bit 0
    assign shr_byte = {alu_shift_in, db_in[`ALU_DATA_W-1:1]}; // Carry-in lands in bit 7

    always_comb
    begin
        if (alu_shift_left)                 // Left has priority
            shift_byte = shl_byte;
        else if (alu_shift_right)
            shift_byte = shr_byte;
        else
            shift_byte = db_in;             // Plain pass-through without a shift
    end

    // Edge bits go to the caller's flag logic for rotate carries
    assign shift_db0 = shift_byte[0];
    assign shift_db7 = shift_byte[`ALU_DATA_W-1];

    // ------------------------------------------------------------
    // Bit selector
    // ------------------------------------------------------------
    always_comb
    begin
        bs_byte = '0;                       // All bits clear
        bs_byte[bsel] = 1'b1;               // Except the selected one
    end

endmodule

/* rtl/alu_pkg.sv */
// Vector types for the nibble ALU; widths follow alu_defines.svh and are not overridable
`include "alu_defines.svh"

package alu_pkg;

    // ------------------------------------------------------------
    // Datapath vectors
    // ------------------------------------------------------------
    // Full byte on the buses, in the operand latches and as a result
    typedef logic [`ALU_DATA_W-1:0] data_t;

    // Half byte processed by the core in one clock
    typedef logic [`ALU_NIB_W-1:0] nibble_t;

    // ------------------------------------------------------------
    // Control vectors
    // ------------------------------------------------------------
    // Which bit the bit selector raises
    typedef logic [`ALU_BSEL_W-1:0] bsel_t;

endpackage

/* rtl/alu_defines.svh */
// Width macros for the nibble ALU; the datapath only works with DATA_W equal to twice NIB_W
`ifndef ALU_DEFINES_SVH
`define ALU_DEFINES_SVH

// ------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------
`define ALU_DATA_W 8            // External and internal data bus
`define ALU_NIB_W  4            // One core step, half a data byte

// ------------------------------------------------------------
// Bit selector
// ------------------------------------------------------------
// Index width must address every bit of the data bus
`define ALU_BSEL_W 3            // Bit index covering the whole byte

`endif
